// ==== list.f ====
src/rename_pkg.sv
src/map_table.sv
src/free_list.sv
src/checkpoint_store.sv
src/rename_unit.sv
test/rename_unit_chk.sv
test/rename_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the rename unit

VERILATOR ?= verilator
TOP ?= rename_unit_tb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert --timing -j 0

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "^TEST RESULT: PASS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/rename_unit_tb.sv ====
`timescale 1ns/1ps

module rename_unit_tb import rename_pkg::*; ();

	localparam int num_rows = 15;
	localparam int num_random = 400;
	localparam real clock_period = 20.0;

	typedef struct {
		rename_op_t           op;
		logic [arch_bits-1:0] a;
		logic [arch_bits-1:0] b;
		logic [arch_bits-1:0] dest;
		logic [phys_bits-1:0] tag;      // CDB or retire tag
		logic                 cdb_too;  // Broadcast alongside a dispatch
		logic [6:0]           exp_a;
		logic [6:0]           exp_b;
		logic [6:0]           exp_old;
		logic [5:0]           exp_new;
	} row_t;

	logic clock;
	logic reset;
	logic dispatch_valid;
	logic [arch_bits-1:0] reg_a;
	logic [arch_bits-1:0] reg_b;
	logic [arch_bits-1:0] reg_dest;
	logic cdb_valid;
	logic [phys_bits-1:0] cdb_tag;
	logic retire_valid;
	logic [phys_bits-1:0] retire_tag;
	logic checkpoint_take;
	logic branch_mispredict;
	logic [entry_bits-1:0] tag_a;
	logic [entry_bits-1:0] tag_b;
	logic [entry_bits-1:0] tag_dest_old;
	logic [phys_bits-1:0] tag_dest_new;
	logic free_empty;

	row_t rows [num_rows];
	int errors = 0;
	logic [31:0] rng_state = 32'h0c43_7f5d;

	// Reference model
	logic [6:0] model_map [num_arch_reg];
	logic [6:0] model_ck_map [num_arch_reg];
	logic [5:0] model_fifo [num_phys_reg];
	logic [5:0] model_rd;
	logic [5:0] model_wr;
	logic [5:0] model_ck_rd;
	int model_count;

	rename_unit rename_unit_i (.*);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	// Watchdog sized from the table, the random phase and some margin
	initial begin
		#((num_rows + num_random + 20) * clock_period);
		$display("Run timed out before all tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, expected);
		end
	endtask

	task automatic reset_model();
		for (int i = 0; i < num_arch_reg; i++) begin
			model_map[i] = {1'b1, 6'(i)};
			model_ck_map[i] = {1'b1, 6'(i)};
		end
		for (int i = 0; i < num_free_reset; i++)
			model_fifo[i] = 6'(num_arch_reg + i);
		model_rd = '0;
		model_wr = 6'(num_free_reset);
		model_ck_rd = '0;
		model_count = num_free_reset;
	endtask

	// One edge of the model where a restore overrides the wakeup and the dispatch write
	task automatic step_model(input logic d, input logic [4:0] dest, input logic c,
			input logic [5:0] ctag, input logic r, input logic [5:0] rtag,
			input logic ck, input logic mp);
		logic [6:0] next_map [num_arch_reg];
		logic [5:0] old_ck_rd;
		old_ck_rd = model_ck_rd;
		for (int i = 0; i < num_arch_reg; i++) begin
			if (mp) begin
				next_map[i] = model_ck_map[i];  // Saved copy as it stood before this edge
			end else begin
				next_map[i] = model_map[i];
				if (c && model_map[i][5:0] == ctag)
					next_map[i][6] = 1'b1;
			end
			if (c && model_ck_map[i][5:0] == ctag)
				model_ck_map[i][6] = 1'b1;  // Saved copy hears the CDB too
		end
		if (!mp && d)
			next_map[dest] = {1'b0, model_fifo[model_rd]};
		if (ck) begin
			for (int i = 0; i < num_arch_reg; i++)
				model_ck_map[i] = next_map[i];
			model_ck_rd = model_rd + 6'(d);
		end
		for (int i = 0; i < num_arch_reg; i++)
			model_map[i] = next_map[i];
		if (r) begin
			model_fifo[model_wr] = rtag;
			model_wr = model_wr + 6'd1;
		end
		if (mp) begin
			model_rd = old_ck_rd;
			model_count = int'(6'(model_wr - old_ck_rd));
		end else begin
			model_rd = model_rd + 6'(d);
			model_count = model_count + int'(r) - int'(d);
		end
	endtask

	// Drive one cycle, check against the model at the falling edge, advance the model
	task automatic apply_cycle(input logic d, input logic [4:0] a, input logic [4:0] b,
			input logic [4:0] dest, input logic c, input logic [5:0] ctag, input logic r,
			input logic [5:0] rtag, input logic ck, input logic mp);
		@(posedge clock);
		dispatch_valid <= d;
		reg_a <= a;
		reg_b <= b;
		reg_dest <= dest;
		cdb_valid <= c;
		cdb_tag <= ctag;
		retire_valid <= r;
		retire_tag <= rtag;
		checkpoint_take <= ck;
		branch_mispredict <= mp;
		@(negedge clock);
		check_value(free_empty, model_count == 0, "free_empty");
		if (d) begin
			check_value(tag_a, model_map[a], "tag_a");
			check_value(tag_b, model_map[b], "tag_b");
			check_value(tag_dest_old, model_map[dest], "tag_dest_old");
			check_value(tag_dest_new, model_fifo[model_rd], "tag_dest_new");
		end
		step_model(d, dest, c, ctag, r, rtag, ck, mp);
	endtask

	task automatic load_table();
		rows[0] = '{op_dispatch, 1, 2, 3, 0, 0, 7'h41, 7'h42, 7'h43, 32};
		rows[1] = '{op_dispatch, 3, 0, 3, 0, 0, 7'h20, 7'h40, 7'h20, 33};
		rows[2] = '{op_cdb, 0, 0, 0, 33, 0, 0, 0, 0, 0};
		rows[3] = '{op_dispatch, 3, 3, 5, 0, 0, 7'h61, 7'h61, 7'h45, 34};
		rows[4] = '{op_dispatch, 5, 0, 5, 35, 1, 7'h22, 7'h40, 7'h22, 35};  // Same-cycle CDB
		rows[5] = '{op_dispatch, 5, 3, 6, 0, 0, 7'h23, 7'h61, 7'h46, 36};
		rows[6] = '{op_checkpoint, 0, 0, 0, 0, 0, 0, 0, 0, 0};
		rows[7] = '{op_dispatch, 6, 1, 1, 0, 0, 7'h24, 7'h41, 7'h41, 37};
		rows[8] = '{op_dispatch, 1, 6, 6, 0, 0, 7'h25, 7'h24, 7'h24, 38};
		rows[9] = '{op_cdb, 0, 0, 0, 36, 0, 0, 0, 0, 0};
		rows[10] = '{op_mispredict, 0, 0, 0, 0, 0, 0, 0, 0, 0};
		rows[11] = '{op_dispatch, 1, 6, 5, 0, 0, 7'h41, 7'h64, 7'h23, 37};  // Tags reused
		rows[12] = '{op_dispatch, 5, 2, 7, 0, 0, 7'h25, 7'h42, 7'h47, 38};
		rows[13] = '{op_retire, 0, 0, 0, 1, 0, 0, 0, 0, 0};
		rows[14] = '{op_idle, 0, 0, 0, 0, 0, 0, 0, 0, 0};
	endtask

	task automatic run_directed();
		row_t row;
		for (int i = 0; i < num_rows; i++) begin
			row = rows[i];
			apply_cycle(row.op == op_dispatch, row.a, row.b, row.dest,
				row.op == op_cdb || row.cdb_too, row.tag, row.op == op_retire, row.tag,
				row.op == op_checkpoint, row.op == op_mispredict);
			if (row.op == op_dispatch) begin
				check_value(tag_a, row.exp_a, $sformatf("row %0d tag_a", i));
				check_value(tag_b, row.exp_b, $sformatf("row %0d tag_b", i));
				check_value(tag_dest_old, row.exp_old, $sformatf("row %0d tag_dest_old", i));
				check_value(tag_dest_new, row.exp_new, $sformatf("row %0d tag_dest_new", i));
			end
		end
	endtask

	task automatic run_random();
		logic [31:0] r;
		logic [31:0] s;
		logic d;
		logic c;
		logic rt;
		logic ck;
		logic mp;
		for (int i = 0; i < num_random; i++) begin
			r = next_random();
			s = next_random();
			d = 1'b0;
			c = s[8];
			rt = 1'b0;
			ck = 1'b0;
			mp = 1'b0;
			case (r[3:0]) inside
				[0:7]: d = (model_count != 0);          // Dispatch heavy to drain the list
				[8:11]: rt = (model_count < 40);
				12: ck = 1'b1;
				13: mp = 1'b1;
				14: begin
					ck = 1'b1;
					d = (model_count != 0);
				end
				default: c = 1'b1;
			endcase
			apply_cycle(d, r[8:4], r[13:9], r[18:14], c, s[5:0], rt, s[14:9], ck, mp);
		end
	endtask

	initial begin
		reset = 1'b1;
		dispatch_valid = 1'b0;
		reg_a = '0;
		reg_b = '0;
		reg_dest = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		retire_valid = 1'b0;
		retire_tag = '0;
		checkpoint_take = 1'b0;
		branch_mispredict = 1'b0;
		load_table();
		reset_model();
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		run_directed();
		run_random();
		@(posedge clock);
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== test/rename_unit_chk.sv ====
`timescale 1ns/1ps

module rename_unit_chk import rename_pkg::*; (
	input logic clock,
	input logic reset,
	input logic dispatch_valid,
	input logic cdb_valid,
	input logic retire_valid,
	input logic checkpoint_take,
	input logic branch_mispredict,
	input logic free_empty
);

	rename_op_t op_now;

	// Dominant operation of the cycle
	always_comb begin
		if (branch_mispredict)
			op_now = op_mispredict;
		else if (checkpoint_take)
			op_now = op_checkpoint;
		else if (dispatch_valid)
			op_now = op_dispatch;
		else if (retire_valid)
			op_now = op_retire;
		else if (cdb_valid)
			op_now = op_cdb;
		else
			op_now = op_idle;
	end

	no_dispatch_when_empty: assert property (@(posedge clock) disable iff (reset)
		dispatch_valid |-> !free_empty)
		else $error("dispatch while the free list is empty");

	no_checkpoint_on_mispredict: assert property (@(posedge clock) disable iff (reset)
		op_now == op_mispredict |-> !checkpoint_take)
		else $error("checkpoint and mispredict in the same cycle");

	free_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> !free_empty)
		else $error("free list empty right after reset");

	// Each kind of operation shows up at least once
	seen_dispatch: cover property (@(posedge clock) disable iff (reset)
		op_now == op_dispatch);
	seen_cdb: cover property (@(posedge clock) disable iff (reset)
		op_now == op_cdb);
	seen_retire: cover property (@(posedge clock) disable iff (reset)
		op_now == op_retire);
	seen_checkpoint: cover property (@(posedge clock) disable iff (reset)
		op_now == op_checkpoint);
	seen_mispredict: cover property (@(posedge clock) disable iff (reset)
		op_now == op_mispredict);

endmodule

bind rename_unit rename_unit_chk rename_unit_chk_i (.*);

// ==== src/rename_unit.sv ====
`timescale 1ns/1ps

module rename_unit import rename_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,

	// Dispatch
	input  logic                  dispatch_valid,
	input  logic [arch_bits-1:0]  reg_a,
	input  logic [arch_bits-1:0]  reg_b,
	input  logic [arch_bits-1:0]  reg_dest,

	// Common data bus
	input  logic                  cdb_valid,
	input  logic [phys_bits-1:0]  cdb_tag,

	// Retire
	input  logic                  retire_valid,
	input  logic [phys_bits-1:0]  retire_tag,

	// Branch handling
	input  logic                  checkpoint_take,
	input  logic                  branch_mispredict,

	output logic [entry_bits-1:0] tag_a,
	output logic [entry_bits-1:0] tag_b,
	output logic [entry_bits-1:0] tag_dest_old,
	output logic [phys_bits-1:0]  tag_dest_new,
	output logic                  free_empty
);

	logic [phys_bits-1:0]                    free_head_tag;
	logic [free_count_bits-1:0]              read_ptr;
	logic [num_arch_reg-1:0][entry_bits-1:0] map_state;
	logic [num_arch_reg-1:0][entry_bits-1:0] saved_map;
	logic [free_count_bits-1:0]              saved_read_ptr;

	assign tag_dest_new = free_head_tag;  // Head of the free list is the new tag

	map_table map_table_i (
		.clock(clock),
		.reset(reset),
		.dispatch_valid(dispatch_valid),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.reg_dest(reg_dest),
		.free_head_tag(free_head_tag),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.branch_mispredict(branch_mispredict),
		.saved_map(saved_map),
		.tag_a(tag_a),
		.tag_b(tag_b),
		.tag_dest_old(tag_dest_old),
		.map_state(map_state)
	);

	free_list free_list_i (
		.clock(clock),
		.reset(reset),
		.dispatch_valid(dispatch_valid),
		.retire_valid(retire_valid),
		.retire_tag(retire_tag),
		.branch_mispredict(branch_mispredict),
		.saved_read_ptr(saved_read_ptr),
		.free_head_tag(free_head_tag),
		.read_ptr(read_ptr),
		.free_empty(free_empty)
	);

	checkpoint_store checkpoint_store_i (
		.clock(clock),
		.reset(reset),
		.checkpoint_take(checkpoint_take),
		.map_state(map_state),
		.read_ptr(read_ptr),
		.dispatch_valid(dispatch_valid),
		.reg_dest(reg_dest),
		.free_head_tag(free_head_tag),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.saved_map(saved_map),
		.saved_read_ptr(saved_read_ptr)
	);

endmodule

// ==== src/checkpoint_store.sv ====
`timescale 1ns/1ps

module checkpoint_store import rename_pkg::*; (
	input  logic                                    clock,
	input  logic                                    reset,

	input  logic                                    checkpoint_take,
	input  logic [num_arch_reg-1:0][entry_bits-1:0] map_state,
	input  logic [free_count_bits-1:0]              read_ptr,

	// Same-cycle dispatch, folded into the snapshot
	input  logic                                    dispatch_valid,
	input  logic [arch_bits-1:0]                    reg_dest,
	input  logic [phys_bits-1:0]                    free_head_tag,

	input  logic                                    cdb_valid,
	input  logic [phys_bits-1:0]                    cdb_tag,

	output logic [num_arch_reg-1:0][entry_bits-1:0] saved_map,
	output logic [free_count_bits-1:0]              saved_read_ptr
);

	logic [num_arch_reg-1:0][entry_bits-1:0] snapshot;
	logic [num_arch_reg-1:0][entry_bits-1:0] saved_woken;

	// Map as it will look after this edge
	always_comb begin
		snapshot = cdb_wakeup(map_state, cdb_valid, cdb_tag);
		if (dispatch_valid)
			snapshot[reg_dest] = {1'b0, free_head_tag};
	end

	// Saved copy keeps catching broadcasts while the branch is open
	assign saved_woken = cdb_wakeup(saved_map, cdb_valid, cdb_tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			saved_map <= reset_map;
			saved_read_ptr <= '0;
		end else if (checkpoint_take) begin
			saved_map <= snapshot;
			saved_read_ptr <= read_ptr + free_count_bits'(dispatch_valid);  // After the pop
		end else begin
			saved_map <= saved_woken;
		end
	end

endmodule

// ==== src/free_list.sv ====
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,

	input  logic                       dispatch_valid,  // Pop one tag
	input  logic                       retire_valid,    // Push one tag
	input  logic [phys_bits-1:0]       retire_tag,

	// Recovery to the checkpointed read pointer
	input  logic                       branch_mispredict,
	input  logic [free_count_bits-1:0] saved_read_ptr,

	output logic [phys_bits-1:0]       free_head_tag,
	output logic [free_count_bits-1:0] read_ptr,
	output logic                       free_empty
);

	logic [phys_bits-1:0]       tag_mem [num_phys_reg];
	logic [free_count_bits-1:0] write_ptr;
	logic [count_bits-1:0]      count;

	logic                       pop;
	logic [free_count_bits-1:0] read_next;
	logic [free_count_bits-1:0] write_next;
	logic [count_bits-1:0]      count_next;

	assign free_head_tag = tag_mem[read_ptr];
	assign free_empty = (count == '0);

	// A dispatch in a mispredict cycle is squashed
	assign pop = dispatch_valid && !branch_mispredict;

	assign write_next = write_ptr + free_count_bits'(retire_valid);

	always_comb begin
		if (branch_mispredict) begin
			read_next = saved_read_ptr;
			// Never more than half full, so the pointer gap is the count
			count_next = {1'b0, write_next - saved_read_ptr};
		end else begin
			read_next = read_ptr + free_count_bits'(pop);
			count_next = count + count_bits'(retire_valid) - count_bits'(pop);
		end
	end

	// Queue storage
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_free_reset; i++) begin
				tag_mem[i] <= phys_bits'(num_arch_reg + i);  // Tags 32 to 63 in order
			end
		end else if (retire_valid) begin
			tag_mem[write_ptr] <= retire_tag;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge clock) begin
		if (reset) begin
			read_ptr <= '0;
			write_ptr <= free_count_bits'(num_free_reset);
			count <= count_bits'(num_free_reset);
		end else begin
			read_ptr <= read_next;
			write_ptr <= write_next;
			count <= count_next;
		end
	end

endmodule

// ==== src/map_table.sv ====
`timescale 1ns/1ps

module map_table import rename_pkg::*; (
	input  logic                                    clock,
	input  logic                                    reset,

	// Dispatch side
	input  logic                                    dispatch_valid,
	input  logic [arch_bits-1:0]                    reg_a,
	input  logic [arch_bits-1:0]                    reg_b,
	input  logic [arch_bits-1:0]                    reg_dest,
	input  logic [phys_bits-1:0]                    free_head_tag,  // Fresh tag from the free list

	// Wakeup from the common data bus
	input  logic                                    cdb_valid,
	input  logic [phys_bits-1:0]                    cdb_tag,

	// Branch recovery
	input  logic                                    branch_mispredict,
	input  logic [num_arch_reg-1:0][entry_bits-1:0] saved_map,

	// Rename results, state before this cycle's updates
	output logic [entry_bits-1:0]                   tag_a,
	output logic [entry_bits-1:0]                   tag_b,
	output logic [entry_bits-1:0]                   tag_dest_old,

	// Whole table for the checkpoint store
	output logic [num_arch_reg-1:0][entry_bits-1:0] map_state
);

	logic [num_arch_reg-1:0][entry_bits-1:0] map_reg;
	logic [num_arch_reg-1:0][entry_bits-1:0] map_woken;
	logic [num_arch_reg-1:0][entry_bits-1:0] map_next;

	// Three read ports, no bypass from this cycle's CDB
	assign tag_a = map_reg[reg_a];
	assign tag_b = map_reg[reg_b];
	assign tag_dest_old = map_reg[reg_dest];

	assign map_state = map_reg;

	// CDB wakeup over all 32 entries
	assign map_woken = cdb_wakeup(map_reg, cdb_valid, cdb_tag);

	// Restore wins; otherwise wakeup first, then the dispatch write
	always_comb begin
		map_next = map_woken;
		if (branch_mispredict) begin
			map_next = saved_map;
		end else if (dispatch_valid) begin
			// New producer, value not yet on the CDB
			map_next[reg_dest] = {1'b0, free_head_tag};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			map_reg <= reset_map;  // Register i on tag i, ready
		end else begin
			map_reg <= map_next;
		end
	end

endmodule

// ==== src/rename_pkg.sv ====
package rename_pkg;

	// Register file sizes
	localparam int num_arch_reg = 32;
	localparam int num_phys_reg = 64;

	// Index and tag widths
	localparam int arch_bits = 5;
	localparam int phys_bits = 6;
	localparam int entry_bits = 7;             // Ready bit on top of the tag
	localparam int ready_bit = entry_bits - 1;

	// Free list pointers wrap at 64, the count needs one bit more
	localparam int free_count_bits = 6;
	localparam int count_bits = free_count_bits + 1;
	localparam int num_free_reset = 32;        // Tags 32 to 63 start out free

	// Identity mapping, every entry ready
	function automatic logic [num_arch_reg-1:0][entry_bits-1:0] build_reset_map();
		logic [num_arch_reg-1:0][entry_bits-1:0] map;
		for (int i = 0; i < num_arch_reg; i++) begin
			map[i] = {1'b1, phys_bits'(i)};
		end
		return map;
	endfunction

	localparam logic [num_arch_reg-1:0][entry_bits-1:0] reset_map = build_reset_map();

	// Sets the ready bit of every entry that holds the broadcast tag
	function automatic logic [num_arch_reg-1:0][entry_bits-1:0] cdb_wakeup(
		input logic [num_arch_reg-1:0][entry_bits-1:0] map_in,
		input logic                                    valid,
		input logic [phys_bits-1:0]                    tag
	);
		logic [num_arch_reg-1:0][entry_bits-1:0] map_out;
		map_out = map_in;
		for (int i = 0; i < num_arch_reg; i++) begin
			if (valid && map_in[i][phys_bits-1:0] == tag)
				map_out[i][ready_bit] = 1'b1;
		end
		return map_out;
	endfunction

	// Operation codes used by the testbench table and the checker
	typedef enum logic [2:0] {
		op_idle,
		op_dispatch,
		op_cdb,
		op_retire,
		op_checkpoint,
		op_mispredict
	} rename_op_t;

endpackage
